//--- design/fpuCtrlDecode.sv
module fpuCtrlDecode import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  fetchPkt_t  in,
  input  logic       inValid,
  output logic       inReady,
  output decodePkt_t out,
  output logic       outValid,
  input  logic       outReady
);

  logic [6:0] op;
  logic [6:0] f7;
  logic [4:0] grp;   // funct7 minus the format bits
  logic [2:0] f3;
  logic [4:0] rs2;
  fpuCtrl_t   ctrl;
  logic       fmt;
  logic       take;

  // builds one legal table entry
  function automatic fpuCtrl_t mkCtrl(
    input logic       regWrite,
    input logic       writeInt,
    input logic [1:0] resultSel,
    input logic [2:0] opCtrl,
    input logic [2:0] resSel,
    input logic [1:0] intResSel,
    input logic       divStart,
    input logic       usesRm
  );
    fpuCtrl_t c;
    c.regWrite  = regWrite;
    c.writeInt  = writeInt;
    c.resultSel = resultSel;
    c.opCtrl    = opCtrl;
    c.resSel    = resSel;
    c.intResSel = intResSel;
    c.divStart  = divStart;
    c.illegal   = 1'b0;
    c.usesRm    = usesRm;
    return c;
  endfunction

  // decoded through the r view
  assign op  = in.instr.r.opcode;
  assign f7  = in.instr.r.funct7;
  assign grp = f7[6:2];
  assign f3  = in.instr.r.funct3;
  assign rs2 = in.regs.rs2;

  always_comb begin
    ctrl = ctrlIllegal;
    case (op)
      opLoadFp:
        case (f3)
          3'b010:  ctrl = mkCtrl(1'b1, 1'b0, resLoad, 3'b000, 3'b000, 2'b00, 1'b0, 1'b0); // flw
          3'b011:  ctrl = mkCtrl(1'b1, 1'b0, resLoad, 3'b001, 3'b000, 2'b00, 1'b0, 1'b0); // fld
          default: ctrl = ctrlIllegal;
        endcase
      opStoreFp:
        case (f3)
          3'b010:  ctrl = mkCtrl(1'b0, 1'b0, resLoad, 3'b010, 3'b000, 2'b00, 1'b0, 1'b0); // fsw
          3'b011:  ctrl = mkCtrl(1'b0, 1'b0, resLoad, 3'b011, 3'b000, 2'b00, 1'b0, 1'b0); // fsd
          default: ctrl = ctrlIllegal;
        endcase
      // opCtrl for fma is {mul only, negate product, negate addend}
      opMadd:  ctrl = mkCtrl(1'b1, 1'b0, resFma, 3'b000, 3'b000, 2'b00, 1'b0, 1'b1);
      opMsub:  ctrl = mkCtrl(1'b1, 1'b0, resFma, 3'b001, 3'b000, 2'b00, 1'b0, 1'b1);
      opNmsub: ctrl = mkCtrl(1'b1, 1'b0, resFma, 3'b010, 3'b000, 2'b00, 1'b0, 1'b1);
      opNmadd: ctrl = mkCtrl(1'b1, 1'b0, resFma, 3'b011, 3'b000, 2'b00, 1'b0, 1'b1);
      opFp:
        case (grp)
          grpAdd: ctrl = mkCtrl(1'b1, 1'b0, resAdd, 3'b110, 3'b000, 2'b00, 1'b0, 1'b1);
          grpSub: ctrl = mkCtrl(1'b1, 1'b0, resAdd, 3'b111, 3'b000, 2'b00, 1'b0, 1'b1);
          grpMul: ctrl = mkCtrl(1'b1, 1'b0, resFma, 3'b100, 3'b000, 2'b00, 1'b0, 1'b1);
          grpDiv: ctrl = mkCtrl(1'b1, 1'b0, resDiv, 3'b000, 3'b000, 2'b00, 1'b1, 1'b1);
          grpSqrt:
            if (rs2 == 5'd0) ctrl = mkCtrl(1'b1, 1'b0, resDiv, 3'b001, 3'b000, 2'b00, 1'b1, 1'b1);
          grpSgnj: // funct3 picks the flavour, no rounding
            case (f3)
              3'b000:  ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b000, 3'b001, 2'b00, 1'b0, 1'b0);
              3'b001:  ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b001, 3'b001, 2'b00, 1'b0, 1'b0);
              3'b010:  ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b010, 3'b001, 2'b00, 1'b0, 1'b0);
              default: ctrl = ctrlIllegal;
            endcase
          grpMinMax:
            case (f3)
              3'b000:  ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b111, 3'b010, 2'b00, 1'b0, 1'b0); // fmin
              3'b001:  ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b101, 3'b010, 2'b00, 1'b0, 1'b0); // fmax
              default: ctrl = ctrlIllegal;
            endcase
          grpCmp: // result lands in the int register file
            case (f3)
              3'b010:  ctrl = mkCtrl(1'b0, 1'b1, resMisc, 3'b010, 3'b000, 2'b00, 1'b0, 1'b0); // feq
              3'b001:  ctrl = mkCtrl(1'b0, 1'b1, resMisc, 3'b001, 3'b000, 2'b00, 1'b0, 1'b0); // flt
              3'b000:  ctrl = mkCtrl(1'b0, 1'b1, resMisc, 3'b011, 3'b000, 2'b00, 1'b0, 1'b0); // fle
              default: ctrl = ctrlIllegal;
            endcase
          grpClassMvX:
            if (rs2 != 5'd0) ctrl = ctrlIllegal;
            else if (f3 == 3'b001) // fclass
              ctrl = mkCtrl(1'b0, 1'b1, resMisc, 3'b000, 3'b000, 2'b10, 1'b0, 1'b0);
            else if (f3 == 3'b000) // fmv.x.w, fmv.x.d by fmt bit
              ctrl = mkCtrl(1'b0, 1'b1, resMisc, {2'b10, f7[0]}, 3'b000, 2'b01, 1'b0, 1'b0);
          grpCvtFromInt: // rs2[1:0] is w, wu, l, lu
            if (rs2[4:2] == 3'b000)
              ctrl = mkCtrl(1'b1, 1'b0, resMisc, {rs2[1:0], 1'b0}, 3'b011, 2'b00, 1'b0, 1'b1);
          grpCvtToInt:
            if (rs2[4:2] == 3'b000)
              ctrl = mkCtrl(1'b0, 1'b1, resMisc, {rs2[1:0], 1'b1}, 3'b011, 2'b11, 1'b0, 1'b1);
          grpCvtFp: // rs2 names the source format
            if (rs2[4:1] == 4'd0)
              ctrl = mkCtrl(1'b1, 1'b0, resMisc, 3'b000, 3'b100, 2'b00, 1'b0, 1'b1);
          grpMvFromX:
            if (rs2 == 5'd0 && f3 == 3'b000) // fmv.w.x / fmv.d.x
              ctrl = mkCtrl(1'b1, 1'b0, resMisc, {2'b00, f7[0]}, 3'b000, 2'b00, 1'b0, 1'b0);
          default: ctrl = ctrlIllegal; // unused group
        endcase
      default: ctrl = ctrlIllegal; // not an fp opcode
    endcase
    // only single and double, half/quad format bits are rejected
    if (op != opLoadFp && op != opStoreFp && f7[1]) ctrl = ctrlIllegal;
  end

  // precision: funct3 width for memory ops, source format for fp->fp
  always_comb begin
    if (op == opLoadFp || op == opStoreFp) begin
      fmt = f3[0];
    end else if (op == opFp && grp == grpCvtFp) begin
      fmt = ~f7[0];
    end else begin
      fmt = f7[0];
    end
  end

  assign inReady = ~outValid | outReady;
  assign take    = inValid & inReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out.ctrl   <= ctrl;
      out.fmt    <= fmt;
      out.funct3 <= f3; // rounding handled downstream
      out.regs   <= in.regs;
    end
  end

endmodule

//--- design/fpuCtrlPkg.sv
package fpuCtrlPkg;
  import fpuIsaPkg::*; // instruction union travels in the fetch packet

  // result mux into the fp register file
  localparam logic [1:0] resLoad = 2'b00; // load data
  localparam logic [1:0] resFma  = 2'b01; // fma unit
  localparam logic [1:0] resAdd  = 2'b01; // add/sub run in the fma unit too
  localparam logic [1:0] resDiv  = 2'b10; // div / sqrt
  localparam logic [1:0] resMisc = 2'b11; // sgnj, minmax, cvt, moves

  // control word, same bit order as the decode table
  typedef struct packed {
    logic       regWrite;  // fp register write
    logic       writeInt;  // result goes to the int register file
    logic [1:0] resultSel;
    logic [2:0] opCtrl;    // per-unit op select
    logic [2:0] resSel;    // misc result select
    logic [1:0] intResSel; // int result select
    logic       divStart;
    logic       illegal;
    logic       usesRm;    // rounding mode matters
  } fpuCtrl_t;

  // default for anything that does not decode
  localparam fpuCtrl_t ctrlIllegal = 15'b0_0_00_000_000_00_0_1_0;

  // register specifiers pulled out in the first stage
  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rs3; // only meaningful for fma
  } fpuRegs_t;

  // latch -> decode
  typedef struct packed {
    fpInstr_u instr;
    fpuRegs_t regs;
  } fetchPkt_t;

  // decode -> issue
  typedef struct packed {
    fpuCtrl_t   ctrl;
    logic       fmt;    // 0 single, 1 double
    logic [2:0] funct3; // raw rm field, not yet resolved
    fpuRegs_t   regs;
  } decodePkt_t;

  // issue -> execute units
  typedef struct packed {
    fpuCtrl_t   ctrl;
    logic       fmt;
    logic [2:0] frm;    // resolved rounding mode
    fpuRegs_t   regs;
  } fpuIssue_t;

endpackage

//--- design/fpuFrontEnd.sv
module fpuFrontEnd import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  fpInstr_u   instr,
  input  logic       instrValid,
  output logic       instrReady,
  input  logic [2:0] csrFrm,
  output fpuIssue_t  issue,
  output logic       issueValid,
  input  logic       issueReady
);

  fetchPkt_t  fetch;   // latch -> decode
  logic       fetchValid;
  logic       fetchReady;
  decodePkt_t dec;     // decode -> issue
  logic       decValid;
  logic       decReady;

  // stage 1, capture and field split
  fpuInstrLatch u_latch (
    .clk(clk), .rst(rst),
    .instr(instr), .inValid(instrValid), .inReady(instrReady),
    .out(fetch), .outValid(fetchValid), .outReady(fetchReady)
  );

  // stage 2, control word
  fpuCtrlDecode u_decode (
    .clk(clk), .rst(rst),
    .in(fetch), .inValid(fetchValid), .inReady(fetchReady),
    .out(dec), .outValid(decValid), .outReady(decReady)
  );

  // stage 3, rounding mode and final illegal flag
  fpuIssue u_issue (
    .clk(clk), .rst(rst),
    .in(dec), .inValid(decValid), .inReady(decReady),
    .csrFrm(csrFrm),
    .out(issue), .outValid(issueValid), .outReady(issueReady)
  );

endmodule

//--- design/fpuInstrLatch.sv
module fpuInstrLatch import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  fpInstr_u  instr,     // raw word from fetch
  input  logic      inValid,
  output logic      inReady,
  output fetchPkt_t out,
  output logic      outValid,
  input  logic      outReady
);

  logic     take;     // word accepted this cycle
  fpuRegs_t regsNext; // specifiers from the incoming word

  // empty, or the held word leaves this cycle
  assign inReady = ~outValid | outReady;
  assign take    = inValid & inReady;

  // field split via the r4 view
  // rs3 is junk for non-fma words, decode ignores it there
  always_comb begin
    regsNext.rd  = instr.r4.rd;
    regsNext.rs1 = instr.r4.rs1;
    regsNext.rs2 = instr.r4.rs2;
    regsNext.rs3 = instr.r4.rs3;
  end

  // valid bit
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid; // refill or drain
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk) begin
    if (take) begin
      out.instr <= instr;
      out.regs  <= regsNext;
    end
  end

endmodule

//--- design/fpuIsaPkg.sv
package fpuIsaPkg;

  // major opcodes of the F and D extensions
  localparam logic [6:0] opLoadFp  = 7'b0000111; // flw / fld
  localparam logic [6:0] opStoreFp = 7'b0100111; // fsw / fsd
  localparam logic [6:0] opMadd    = 7'b1000011;
  localparam logic [6:0] opMsub    = 7'b1000111;
  localparam logic [6:0] opNmsub   = 7'b1001011;
  localparam logic [6:0] opNmadd   = 7'b1001111;
  localparam logic [6:0] opFp      = 7'b1010011; // everything else in OP-FP

  // funct7[6:2] groups of OP-FP
  // funct7[1:0] carries the format and is checked on its own
  localparam logic [4:0] grpAdd       = 5'b00000;
  localparam logic [4:0] grpSub       = 5'b00001;
  localparam logic [4:0] grpMul       = 5'b00010;
  localparam logic [4:0] grpDiv       = 5'b00011;
  localparam logic [4:0] grpSqrt      = 5'b01011;
  localparam logic [4:0] grpSgnj      = 5'b00100; // fsgnj, fsgnjn, fsgnjx
  localparam logic [4:0] grpMinMax    = 5'b00101;
  localparam logic [4:0] grpCmp       = 5'b10100; // feq, flt, fle
  localparam logic [4:0] grpClassMvX  = 5'b11100; // fclass and fmv to int reg
  localparam logic [4:0] grpCvtFp     = 5'b01000; // fcvt.s.d / fcvt.d.s
  localparam logic [4:0] grpCvtToInt  = 5'b11000; // fcvt.w*.s, fcvt.l*.d ...
  localparam logic [4:0] grpCvtFromInt = 5'b11010; // fcvt.s.w*, fcvt.d.l* ...
  localparam logic [4:0] grpMvFromX   = 5'b11110; // fmv.w.x / fmv.d.x

  // rounding modes, as found in funct3 and in frm
  localparam logic [2:0] rmRne = 3'b000; // nearest, ties to even
  localparam logic [2:0] rmRtz = 3'b001; // toward zero
  localparam logic [2:0] rmRdn = 3'b010; // toward -inf
  localparam logic [2:0] rmRup = 3'b011; // toward +inf
  localparam logic [2:0] rmRmm = 3'b100; // nearest, ties away from zero
  localparam logic [2:0] rmDyn = 3'b111; // take frm from the csr

  // R4 layout used by the fused multiply-add opcodes
  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;     // 00 single, 01 double
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;  // rounding mode here
    logic [4:0] rd;
    logic [6:0] opcode;
  } fpR4_t;

  // R layout of OP-FP, loads and stores line up on funct3/opcode
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;     // also selects the int width on conversions
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fpR_t;

  // same 32 bits, two decodings
  typedef union packed {
    fpR4_t r4;
    fpR_t  r;
  } fpInstr_u;

endpackage

//--- design/fpuIssue.sv
module fpuIssue import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  decodePkt_t in,
  input  logic       inValid,
  output logic       inReady,
  input  logic [2:0] csrFrm,   // frm from the csr
  output fpuIssue_t  out,
  output logic       outValid,
  input  logic       outReady
);

  logic [2:0] frm;      // mode after dyn substitution
  logic       rmLegal;  // one of the five defined modes
  logic       badRm;
  fpuIssue_t  pkt;
  logic       take;

  // dyn pulls the csr value in, sampled as the packet enters
  assign frm = (in.funct3 == rmDyn) ? csrFrm : in.funct3;

  // 101, 110 and 111 are reserved once resolved
  assign rmLegal = frm inside {rmRne, rmRtz, rmRdn, rmRup, rmRmm};
  assign badRm   = in.ctrl.usesRm & ~rmLegal;

  always_comb begin
    pkt.ctrl = in.ctrl;
    pkt.fmt  = in.fmt;
    pkt.frm  = frm;
    pkt.regs = in.regs;
    pkt.ctrl.illegal = in.ctrl.illegal | badRm;
    // nothing illegal may write or start the divider
    if (pkt.ctrl.illegal) begin
      pkt.ctrl.regWrite = 1'b0;
      pkt.ctrl.writeInt = 1'b0;
      pkt.ctrl.divStart = 1'b0;
    end
  end

  assign inReady = ~outValid | outReady;
  assign take    = inValid & inReady;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
    end else if (inReady) begin
      outValid <= inValid;
    end
  end

  // issue packet, held under back-pressure
  always_ff @(posedge clk) begin
    if (take) begin
      out <= pkt;
    end
  end

endmodule

//--- filelist.f
design/fpuIsaPkg.sv
design/fpuCtrlPkg.sv
design/fpuInstrLatch.sv
design/fpuCtrlDecode.sv
design/fpuIssue.sv
design/fpuFrontEnd.sv
tests/fpuFrontEnd_asserts.sv
tests/fpuFrontEnd_tb.sv

//--- runSim.sh
#!/bin/sh
# Build and run the FPU front end testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f filelist.f --top-module fpuFrontEnd_tb --Mdir obj_dir -o simFpuFrontEnd
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/simFpuFrontEnd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

//--- tests/fpuFrontEnd_asserts.sv
module fpuFrontEnd_asserts import fpuIsaPkg::*, fpuCtrlPkg::*; (
  input logic      clk,
  input logic      rst,
  input fpuIssue_t issue,
  input logic      issueValid,
  input logic      issueReady
);
  timeunit 1ns;
  timeprecision 100ps;

  // a stalled packet holds still until the execute side takes it
  stallHold: assert property (@(posedge clk) disable iff (rst)
    issueValid && !issueReady |=> issueValid && $stable(issue))
    else $error("issue packet changed or dropped while issueReady was low");

  resetEmpty: assert property (@(posedge clk) rst |=> !issueValid) // empty out of reset
    else $error("issueValid high in the cycle after reset");

  // 101, 110 and 111 are reserved rounding modes
  rmReserved: assert property (@(posedge clk) disable iff (rst)
    issueValid && issue.ctrl.usesRm && !issue.ctrl.illegal
      |-> !(issue.frm inside {3'b101, 3'b110, 3'b111}))
    else $error("legal rounding op issued with a reserved frm %b", issue.frm);

endmodule

bind fpuFrontEnd fpuFrontEnd_asserts u_asserts (
  .clk(clk),
  .rst(rst),
  .issue(issue),
  .issueValid(issueValid),
  .issueReady(issueReady)
);

//--- tests/fpuFrontEnd_tb.sv
module fpuFrontEnd_tb import fpuIsaPkg::*, fpuCtrlPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxWait = 100; // cycles allowed per wait

  logic       clk;
  logic       rst;
  fpInstr_u   instr;
  logic       instrValid;
  logic       instrReady;
  logic [2:0] csrFrm;
  fpuIssue_t  issue;
  logic       issueValid;
  logic       issueReady;
  int         ctrlErrs = 0;
  int         regErrs = 0;
  int         fieldErrs = 0;
  int         flowErrs = 0;  // timeouts, latency, ready, ordering
  int         seed = 13278;
  fpuRegs_t   expQ[$];       // back-pressure reference order
  logic [2:0] frmQ[$];

  fpuFrontEnd i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkCtrl(input fpuCtrl_t got, input fpuCtrl_t exp, input string what);
    if (got !== exp) begin
      ctrlErrs++;
      $display("FAIL %0t: %s ctrl %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkRegs(input fpuRegs_t got, input fpuRegs_t exp, input string what);
    if (got !== exp) begin
      regErrs++;
      $display("FAIL %0t: %s regs %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFields(input logic gotFmt, input logic [2:0] gotFrm,
      input logic expFmt, input logic [2:0] expFrm, input string what);
    if (gotFmt !== expFmt || gotFrm !== expFrm) begin
      fieldErrs++;
      $display("FAIL %0t: %s fmt %b frm %b, expected fmt %b frm %b",
        $time, what, gotFmt, gotFrm, expFmt, expFrm);
    end
  endtask

  // word held until instrReady then taken on the next edge
  task automatic sendInstr(input fpInstr_u w);
    int n;
    instr = w;
    instrValid = 1'b1;
    n = 0;
    @(negedge clk);
    while (!instrReady && n < maxWait) begin
      @(negedge clk);
      n++;
    end
    if (!instrReady) begin
      flowErrs++;
      $display("timeout at %0t: instrReady stayed low", $time);
    end
    @(posedge clk);
    #1 instrValid = 1'b0;
  endtask

  // cycles counts falling edges until issueValid shows up
  task automatic waitIssue(output fpuIssue_t got, output int cycles);
    cycles = 1;
    @(negedge clk);
    while (!issueValid && cycles < maxWait) begin
      @(negedge clk);
      cycles++;
    end
    if (!issueValid) begin
      flowErrs++;
      $display("timeout at %0t: issueValid never rose", $time);
    end
    got = issue;
    @(posedge clk); // issueReady high so it leaves here
    #1;
  endtask

  // every word uses rd 1 and rs1 2
  task automatic runOne(input logic [6:0] f7, input logic [4:0] rs2, input logic [2:0] f3,
      input logic [6:0] op, input fpuCtrl_t expCtrl, input logic expFmt,
      input logic [2:0] expFrm, input string what);
    fpuIssue_t got;
    int        cycles;
    sendInstr({f7, rs2, 5'd2, f3, 5'd1, op});
    waitIssue(got, cycles);
    if (cycles != 3) begin
      flowErrs++;
      $display("FAIL %0t: %s issued after %0d cycles, expected 3", $time, what, cycles);
    end
    checkCtrl(got.ctrl, expCtrl, what);
    checkRegs(got.regs, {5'd1, 5'd2, rs2, f7[6:2]}, what); // rs3 is funct7[6:2]
    checkFields(got.fmt, got.frm, expFmt, expFrm, what);
  endtask

  // ctrl literals list regWrite writeInt resultSel opCtrl resSel intResSel divStart
  // illegal usesRm
  // expected fmt and frm come after the ctrl literal
  task automatic testMemOps();
    runOne(7'b0000000, 5'd3, 3'b010, opLoadFp, 15'b1_0_00_000_000_00_0_0_0, 1'b0, 3'b010, "flw");
    runOne(7'b0000000, 5'd3, 3'b011, opLoadFp, 15'b1_0_00_001_000_00_0_0_0, 1'b1, 3'b011, "fld");
    runOne(7'b0000000, 5'd3, 3'b010, opStoreFp, 15'b0_0_00_010_000_00_0_0_0, 1'b0, 3'b010, "fsw");
    runOne(7'b0000000, 5'd3, 3'b011, opStoreFp, 15'b0_0_00_011_000_00_0_0_0, 1'b1, 3'b011, "fsd");
    runOne(7'b0000000, 5'd3, 3'b000, opLoadFp, 15'b0_0_00_000_000_00_0_1_0, 1'b0, 3'b000,
      "load f3 0");
  endtask

  task automatic testArith();
    runOne(7'b0010000, 5'd3, rmRne, opMadd, 15'b1_0_01_000_000_00_0_0_1, 1'b0, rmRne, "fmadd.s");
    runOne(7'b0010101, 5'd3, rmRtz, opNmadd, 15'b1_0_01_011_000_00_0_0_1, 1'b1, rmRtz, "fnmadd.d");
    runOne(7'b0000000, 5'd3, rmRdn, opFp, 15'b1_0_01_110_000_00_0_0_1, 1'b0, rmRdn, "fadd.s");
    runOne(7'b0000101, 5'd3, rmRup, opFp, 15'b1_0_01_111_000_00_0_0_1, 1'b1, rmRup, "fsub.d");
    runOne(7'b0001000, 5'd3, rmRmm, opFp, 15'b1_0_01_100_000_00_0_0_1, 1'b0, rmRmm, "fmul.s");
    runOne(7'b0001101, 5'd3, rmRne, opFp, 15'b1_0_10_000_000_00_1_0_1, 1'b1, rmRne, "fdiv.d");
    runOne(7'b0101100, 5'd0, rmRtz, opFp, 15'b1_0_10_001_000_00_1_0_1, 1'b0, rmRtz, "fsqrt.s");
  endtask

  task automatic testRounding();
    csrFrm = rmRup;
    runOne(7'b0000000, 5'd3, rmDyn, opFp, 15'b1_0_01_110_000_00_0_0_1, 1'b0, rmRup, "fadd.s dyn");
    csrFrm = 3'b101; // reserved
    runOne(7'b0001001, 5'd3, rmDyn, opFp, 15'b0_0_01_100_000_00_0_1_1, 1'b1, 3'b101, "fmul.d dyn");
    runOne(7'b0001100, 5'd3, 3'b110, opFp, 15'b0_0_10_000_000_00_0_1_1, 1'b0, 3'b110,
      "fdiv.s rm 6");
    runOne(7'b0010001, 5'd3, 3'b010, opFp, 15'b1_0_11_010_001_00_0_0_0, 1'b1, 3'b010, "fsgnjx.d");
    csrFrm = rmRne;
  endtask

  task automatic testIntResults();
    runOne(7'b1010000, 5'd3, 3'b010, opFp, 15'b0_1_11_010_000_00_0_0_0, 1'b0, 3'b010, "feq.s");
    runOne(7'b1010001, 5'd3, 3'b001, opFp, 15'b0_1_11_001_000_00_0_0_0, 1'b1, 3'b001, "flt.d");
    runOne(7'b1010000, 5'd3, 3'b000, opFp, 15'b0_1_11_011_000_00_0_0_0, 1'b0, 3'b000, "fle.s");
    runOne(7'b1110001, 5'd0, 3'b001, opFp, 15'b0_1_11_000_000_10_0_0_0, 1'b1, 3'b001, "fclass.d");
    runOne(7'b1110000, 5'd0, 3'b000, opFp, 15'b0_1_11_100_000_01_0_0_0, 1'b0, 3'b000, "fmv.x.w");
    runOne(7'b1100001, 5'd0, rmRtz, opFp, 15'b0_1_11_001_011_11_0_0_1, 1'b1, rmRtz, "fcvt.w.d");
    // fp->fp conversion reports the source format (double)
    runOne(7'b0100000, 5'd1, rmRne, opFp, 15'b1_0_11_000_100_00_0_0_1, 1'b1, rmRne, "fcvt.s.d");
    runOne(7'b1111001, 5'd0, 3'b000, opFp, 15'b1_0_11_001_000_00_0_0_0, 1'b1, 3'b000, "fmv.d.x");
  endtask

  task automatic testIllegal();
    runOne(7'b0000000, 5'd3, 3'b000, 7'b0110011, 15'b0_0_00_000_000_00_0_1_0, 1'b0, 3'b000,
      "int op");
    runOne(7'b0111100, 5'd3, 3'b000, opFp, 15'b0_0_00_000_000_00_0_1_0, 1'b0, 3'b000,
      "group 01111");
    runOne(7'b0010100, 5'd3, 3'b010, opFp, 15'b0_0_00_000_000_00_0_1_0, 1'b0, 3'b010, "fmin f3 2");
  endtask

  task automatic testBackPressure();
    fpuIssue_t   got;
    int          cycles;
    int          rcvd;
    int          n;
    logic [31:0] w;
    logic [2:0]  f3;
    logic [31:0] words[$]; // drawn up front, consumer alone draws during the run
    rcvd = 0;
    n = 0;
    for (int i = 0; i < 40; i++) begin
      f3 = 3'(($random(seed) & 255) % 5); // static modes only
      w = {7'b0000001, 5'($random(seed)), 5'($random(seed)), f3, 5'($random(seed)), opFp};
      expQ.push_back({w[11:7], w[19:15], w[24:20], w[31:27]});
      frmQ.push_back(f3);
      words.push_back(w);
    end
    fork
      begin : producer
        for (int i = 0; i < 40; i++) begin
          sendInstr(words[i]);
        end
      end
      begin : consumer
        while (rcvd < 40 && n < 40 * maxWait) begin
          @(posedge clk);
          #1 issueReady = 1'($random(seed));
          @(negedge clk);
          if (issueValid && issueReady) begin // leaves on the next edge
            checkRegs(issue.regs, expQ.pop_front(), "back-pressure order");
            checkFields(issue.fmt, issue.frm, 1'b1, frmQ.pop_front(), "back-pressure frm");
            rcvd++;
          end
          n++;
        end
      end
    join
    if (rcvd != 40) begin
      flowErrs++;
      $display("FAIL %0t: back-pressure run issued %0d of 40 packets", $time, rcvd);
    end
    @(posedge clk);
    #1 issueReady = 1'b0;
    for (int i = 0; i < 3; i++) begin
      sendInstr({7'b0000001, 5'd3, 5'(i), rmRne, 5'(i + 10), opFp});
    end
    @(negedge clk);
    if (instrReady) begin // all three stages hold a packet
      flowErrs++;
      $display("FAIL %0t: instrReady high with every stage full", $time);
    end
    @(posedge clk);
    #1 issueReady = 1'b1;
    for (int i = 0; i < 3; i++) begin
      waitIssue(got, cycles);
      checkRegs(got.regs, {5'(i + 10), 5'(i), 5'd3, 5'd0}, "drain after stall");
    end
  endtask

  initial begin
    rst = 1'b1;
    instr = '0;
    instrValid = 1'b0;
    csrFrm = rmRne;
    issueReady = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    if (!instrReady || issueValid) begin
      flowErrs++;
      $display("FAIL %0t: after reset instrReady %b issueValid %b", $time, instrReady, issueValid);
    end
    @(posedge clk);
    #1;
    testMemOps();
    testArith();
    testRounding();
    testIntResults();
    testIllegal();
    testBackPressure();
    $display("errors: ctrl %0d, regs %0d, fmt/frm %0d, flow %0d",
      ctrlErrs, regErrs, fieldErrs, flowErrs);
    if (ctrlErrs + regErrs + fieldErrs + flowErrs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
